// File: Bender.yml
package:
  name: memoryController

sources:
  - common/memPkg.sv
  - src/memory/bootRom.sv
  - src/memory/ramBank.sv
  - src/peripherals/uartTx.sv
  - src/peripherals/gpioPort.sv
  - src/peripherals/pwmLed.sv
  - src/memoryController.sv
  - target: test
    files:
      - tests/memoryControllerTb.sv

// File: common/memPkg.sv
// memory package with bus word types, address map and peripheral constants
package memPkg;

	typedef logic [15:0] wordT;
	typedef logic [15:0] addrT;
	typedef logic [7:0] regOffsetT; // low address byte
	typedef logic [11:0] romAddrT; // 4k words
	typedef logic [13:0] ramAddrT; // 16k words
	typedef logic [7:0] dutyT; // pwm duty and counter

	localparam int CLOCK_FREQ = 10_000_000;
	localparam int BAUD_RATE = 115200;
	localparam int BAUD_DIV = CLOCK_FREQ / BAUD_RATE; // 86 clocks per bit

	localparam int GPIO_OUT_BITS = 4;
	localparam int GPIO_IN_BITS = 6;
	localparam int PWM_CHANNELS = 3;

	// address map, each compared against the top bits of ADDRESS
	localparam logic [3:0] ROM_REGION = 4'h0; // 0x0000 - 0x0fff
	localparam logic [7:0] UART_PAGE = 8'h10; // 0x10xx
	localparam logic [7:0] GPIO_PAGE = 8'h11; // 0x11xx
	localparam logic [7:0] PWM_PAGE = 8'h12; // 0x12xx
	localparam logic [1:0] RAM_REGION = 2'b10; // 0x8000 - 0xbfff

endpackage

// File: memoryController.f
common/memPkg.sv
src/memory/bootRom.sv
src/memory/ramBank.sv
src/peripherals/uartTx.sv
src/peripherals/gpioPort.sv
src/peripherals/pwmLed.sv
src/memoryController.sv
tests/memoryControllerTb.sv

// File: src/memory/bootRom.hex
// one 16-bit word per line, word i is i * 0x0101 xor 0xa5a5
A5A5
A4A4
A7A7
A6A6
A1A1
A0A0
A3A3
A2A2
ADAD
ACAC
AFAF
AEAE
A9A9
A8A8
ABAB
AAAA
B5B5
B4B4
B7B7
B6B6
B1B1
B0B0
B3B3
B2B2
BDBD
BCBC
BFBF
BEBE
B9B9
B8B8
BBBB
BABA

// File: src/memory/bootRom.sv
// boot ROM, 4k words with registered read, loaded from a hex image
`timescale 1ns/1ps

module bootRom import memPkg::*; (
	input logic CLK,
	input romAddrT addr,
	output wordT data
);

	wordT mem [2**$bits(romAddrT)];

	initial begin
		// words past the end of the image stay zero
		for (int i = 0; i < 2**$bits(romAddrT); i++) begin
			mem[i] = '0;
		end
		$readmemh("src/memory/bootRom.hex", mem);
	end

	always_ff @(posedge CLK) begin
		data <= mem[addr];
	end

endmodule

// File: src/memory/ramBank.sv
// single-port RAM bank, 16k words with synchronous read
`timescale 1ns/1ps

module ramBank import memPkg::*; (
	input logic CLK,
	input ramAddrT addr,
	input wordT wrData,
	input logic we,
	output wordT rdData
);

	wordT mem [2**$bits(ramAddrT)];

	always_ff @(posedge CLK) begin
		if (we) begin
			mem[addr] <= wrData;
		end
		rdData <= mem[addr]; // old data on a write cycle
	end

endmodule

// File: src/memoryController.sv
// memory controller, decodes the bus to ROM, RAM and peripherals with a registered read path
`timescale 1ns/1ps

module memoryController import memPkg::*; (
	input logic CLK,
	input logic RSTb,
	input addrT ADDRESS,
	input wordT DATA_IN,
	output wordT DATA_OUT,
	input logic memWR,
	output logic txPin,
	output logic [GPIO_OUT_BITS-1:0] gpioOut,
	input logic [GPIO_IN_BITS-1:0] gpioIn,
	output logic [PWM_CHANNELS-1:0] ledPins
);

	logic romHit;
	logic ramHit;
	logic uartHit;
	logic gpioHit;
	logic pwmHit;

	logic ramWe;
	logic uartWe;
	logic gpioWe;
	logic pwmWe;

	wordT romData;
	wordT ramData;
	wordT uartData;
	wordT gpioData;
	wordT pwmData;

	wordT periphData;
	wordT periphReg;
	logic romSel;
	logic ramSel;

	regOffsetT regAddr;

	assign regAddr = ADDRESS[7:0]; // peripherals see only the offset

	// address decode
	assign romHit = ADDRESS[15:12] == ROM_REGION;
	assign uartHit = ADDRESS[15:8] == UART_PAGE;
	assign gpioHit = ADDRESS[15:8] == GPIO_PAGE;
	assign pwmHit = ADDRESS[15:8] == PWM_PAGE;
	assign ramHit = ADDRESS[15:14] == RAM_REGION;

	// rom and unmapped writes go nowhere
	assign ramWe = memWR & ramHit;
	assign uartWe = memWR & uartHit;
	assign gpioWe = memWR & gpioHit;
	assign pwmWe = memWR & pwmHit;

	always_comb begin
		periphData = '0;
		if (uartHit) begin
			periphData = uartData;
		end else if (gpioHit) begin
			periphData = gpioData;
		end else if (pwmHit) begin
			periphData = pwmData;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			romSel <= 1'b0;
			ramSel <= 1'b0;
			periphReg <= '0;
		end else begin
			romSel <= romHit;
			ramSel <= ramHit;
			periphReg <= periphData;
		end
	end

	// periphReg is already zero for unmapped reads
	always_comb begin
		if (romSel) begin
			DATA_OUT = romData;
		end else if (ramSel) begin
			DATA_OUT = ramData;
		end else begin
			DATA_OUT = periphReg;
		end
	end

	bootRom theRom (
		.CLK(CLK),
		.addr(ADDRESS[11:0]),
		.data(romData)
	);

	ramBank theRam (
		.CLK(CLK),
		.addr(ADDRESS[13:0]),
		.wrData(DATA_IN),
		.we(ramWe),
		.rdData(ramData)
	);

	uartTx u0 (
		.CLK(CLK),
		.RSTb(RSTb),
		.regAddr(regAddr),
		.wrData(DATA_IN),
		.we(uartWe),
		.rdData(uartData),
		.txPin(txPin)
	);

	gpioPort g0 (
		.CLK(CLK),
		.RSTb(RSTb),
		.regAddr(regAddr),
		.wrData(DATA_IN),
		.we(gpioWe),
		.rdData(gpioData),
		.pinsOut(gpioOut),
		.pinsIn(gpioIn)
	);

	pwmLed led0 (
		.CLK(CLK),
		.RSTb(RSTb),
		.regAddr(regAddr),
		.wrData(DATA_IN),
		.we(pwmWe),
		.rdData(pwmData),
		.ledPins(ledPins)
	);

endmodule

// File: src/peripherals/gpioPort.sv
// GPIO port with an output register and two-flop synchronized inputs
`timescale 1ns/1ps

module gpioPort import memPkg::*; (
	input logic CLK,
	input logic RSTb,
	input regOffsetT regAddr,
	input wordT wrData,
	input logic we,
	output wordT rdData,
	output logic [GPIO_OUT_BITS-1:0] pinsOut,
	input logic [GPIO_IN_BITS-1:0] pinsIn
);

	logic [GPIO_IN_BITS-1:0] syncA;
	logic [GPIO_IN_BITS-1:0] syncB;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pinsOut <= '0;
		end else if (we && regAddr == 8'h00) begin
			pinsOut <= wrData[GPIO_OUT_BITS-1:0];
		end
	end

	// pins are asynchronous to CLK
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			syncA <= '0;
			syncB <= '0;
		end else begin
			syncA <= pinsIn;
			syncB <= syncA;
		end
	end

	always_comb begin
		rdData = '0;
		case (regAddr)
			8'h00: rdData[GPIO_OUT_BITS-1:0] = pinsOut;
			8'h01: rdData[GPIO_IN_BITS-1:0] = syncB;
			default: ;
		endcase
	end

endmodule

// File: src/peripherals/pwmLed.sv
// PWM LED driver, one duty register per channel against a shared counter
`timescale 1ns/1ps

module pwmLed import memPkg::*; (
	input logic CLK,
	input logic RSTb,
	input regOffsetT regAddr,
	input wordT wrData,
	input logic we,
	output wordT rdData,
	output logic [PWM_CHANNELS-1:0] ledPins
);

	dutyT duty [PWM_CHANNELS];
	dutyT pwmCnt;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < PWM_CHANNELS; i++) begin
				duty[i] <= '0;
			end
		end else begin
			for (int i = 0; i < PWM_CHANNELS; i++) begin
				if (we && regAddr == i) begin
					duty[i] <= wrData[$bits(dutyT)-1:0];
				end
			end
		end
	end

	// free running, wraps at 255
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pwmCnt <= '0;
		end else begin
			pwmCnt <= pwmCnt + 1'b1;
		end
	end

	// duty high cycles per 256
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			ledPins <= '0;
		end else begin
			for (int i = 0; i < PWM_CHANNELS; i++) begin
				ledPins[i] <= pwmCnt < duty[i];
			end
		end
	end

	always_comb begin
		rdData = '0;
		for (int i = 0; i < PWM_CHANNELS; i++) begin
			if (regAddr == i) begin
				rdData[$bits(dutyT)-1:0] = duty[i];
			end
		end
	end

endmodule

// File: src/peripherals/uartTx.sv
// serial transmitter, 8N1 frames from a register write, busy flag at offset 1
`timescale 1ns/1ps

module uartTx import memPkg::*; (
	input logic CLK,
	input logic RSTb,
	input regOffsetT regAddr,
	input wordT wrData,
	input logic we,
	output wordT rdData,
	output logic txPin
);

	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} uartStateT;

	uartStateT state;
	logic [$clog2(BAUD_DIV)-1:0] baudCnt;
	logic [2:0] bitIdx;
	logic [7:0] shiftReg;
	logic busy;
	logic bitDone;

	assign busy = state != IDLE;
	assign bitDone = baudCnt == BAUD_DIV - 1;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= IDLE;
			baudCnt <= '0;
			bitIdx <= '0;
			txPin <= 1'b1; // line idles high
		end else begin
			case (state)
				IDLE: begin
					if (we && regAddr == 8'h00) begin
						state <= START;
						txPin <= 1'b0; // start bit from the next cycle
						baudCnt <= '0;
					end
				end
				START: begin
					baudCnt <= bitDone ? '0 : baudCnt + 1'b1;
					if (bitDone) begin
						state <= DATA;
						bitIdx <= '0;
						txPin <= shiftReg[0];
					end
				end
				DATA: begin
					baudCnt <= bitDone ? '0 : baudCnt + 1'b1;
					if (bitDone) begin
						if (bitIdx == 3'd7) begin
							state <= STOP;
							txPin <= 1'b1;
						end else begin
							bitIdx <= bitIdx + 1'b1;
							txPin <= shiftReg[0];
						end
					end
				end
				STOP: begin
					baudCnt <= bitDone ? '0 : baudCnt + 1'b1;
					if (bitDone) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// data byte, lsb first
	always_ff @(posedge CLK) begin
		if (state == IDLE && we && regAddr == 8'h00) begin
			shiftReg <= wrData[7:0];
		end else if ((state == START || state == DATA) && bitDone) begin
			shiftReg <= shiftReg >> 1;
		end
	end

	always_comb begin
		rdData = '0;
		if (regAddr == 8'h01) begin
			rdData[0] = busy;
		end
	end

endmodule

// File: tests/memoryControllerTb.sv
// testbench for the memory controller with directed bus, memory and peripheral checks
`timescale 1ns/1ps

module memoryControllerTb import memPkg::*; ();

	localparam int TIMEOUT_CYCLES = 6000;
	localparam int RAM_WRITES = 64;
	localparam logic [31:0] SEED = 32'h8e77_c49d;

	localparam addrT UART_DATA = 16'h1000;
	localparam addrT UART_STATUS = 16'h1001;
	localparam addrT GPIO_OUT_REG = 16'h1100;
	localparam addrT GPIO_IN_REG = 16'h1101;
	localparam addrT PWM_BASE = 16'h1200;

	logic CLK;
	logic RSTb;
	addrT ADDRESS;
	wordT DATA_IN;
	wordT DATA_OUT;
	logic memWR;
	logic txPin;
	logic [GPIO_OUT_BITS-1:0] gpioOut;
	logic [GPIO_IN_BITS-1:0] gpioIn;
	logic [PWM_CHANNELS-1:0] ledPins;

	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int seedValue;

	wordT ramModel [2**$bits(ramAddrT)];
	addrT ramAddrs [$];

	memoryController uut (
		.CLK(CLK),
		.RSTb(RSTb),
		.ADDRESS(ADDRESS),
		.DATA_IN(DATA_IN),
		.DATA_OUT(DATA_OUT),
		.memWR(memWR),
		.txPin(txPin),
		.gpioOut(gpioOut),
		.gpioIn(gpioIn),
		.ledPins(ledPins)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK; // 125 MHz in sim time
	end

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
	end

	initial begin
		wait (cycleCount >= TIMEOUT_CYCLES);
		$display("timeout after %0d cycles, the tests did not finish", cycleCount);
		$display("Test failed");
		$finish;
	end

	task automatic checkWord(input string name, input wordT expected, input wordT actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkPin(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	// called on a falling edge and returns on the next one
	task automatic busWrite(input addrT addr, input wordT data);
		ADDRESS = addr;
		DATA_IN = data;
		memWR = 1'b1;
		@(negedge CLK);
		memWR = 1'b0;
	endtask

	task automatic busRead(input addrT addr, output wordT data);
		ADDRESS = addr;
		memWR = 1'b0;
		@(negedge CLK);
		data = DATA_OUT; // word for addr one clock later
	endtask

	task automatic resetState();
		wordT status;
		checkWord("DATA_OUT", 16'h0000, DATA_OUT);
		checkPin("txPin", 1'b1, txPin);
		checkWord("gpioOut", 16'h0000, wordT'(gpioOut));
		checkWord("ledPins", 16'h0000, wordT'(ledPins));
		busRead(UART_STATUS, status);
		checkWord("uart status", 16'h0000, status);
	endtask

	task automatic romReadback();
		wordT data;
		wordT expected;
		for (int i = 0; i < 32; i++) begin
			expected = wordT'(i * 16'h0101) ^ 16'hA5A5;
			busRead(addrT'(i), data);
			checkWord($sformatf("ROM word %0d", i), expected, data);
		end
		busRead(16'h0020, data); // past the image
		checkWord("ROM word 32", 16'h0000, data);
		busRead(16'h0FFF, data);
		checkWord("ROM word 4095", 16'h0000, data);
		busWrite(16'h0007, 16'h1234);
		busRead(16'h0007, data);
		checkWord("ROM word 7 after write", 16'h0707 ^ 16'hA5A5, data);
	endtask

	task automatic ramReadback();
		addrT addr;
		wordT data;
		wordT value;
		for (int i = 0; i < RAM_WRITES; i++) begin
			addr = addrT'(16'h8000 | ($urandom & 32'h3FFF));
			value = wordT'($urandom);
			ramModel[addr[13:0]] = value;
			ramAddrs.push_back(addr);
			busWrite(addr, value);
		end
		for (int i = 0; i < ramAddrs.size(); i++) begin
			addr = ramAddrs[i];
			busRead(addr, data);
			checkWord($sformatf("RAM[%h]", addr), ramModel[addr[13:0]], data);
		end
		ramModel[14'h0000] = 16'hC0DE;
		ramModel[14'h3FFF] = 16'h5AA5;
		busWrite(16'h8000, 16'hC0DE);
		busWrite(16'hBFFF, 16'h5AA5);
		busRead(16'h8000, data);
		checkWord("RAM first word", 16'hC0DE, data);
		busRead(16'hBFFF, data);
		checkWord("RAM last word", 16'h5AA5, data);

		// one read per cycle across ROM, RAM and unmapped space
		addr = ramAddrs[3];
		busRead(16'h0003, data);
		checkWord("pipelined ROM word 3", 16'h0303 ^ 16'hA5A5, data);
		busRead(addr, data);
		checkWord($sformatf("pipelined RAM[%h]", addr), ramModel[addr[13:0]], data);
		busRead(16'h5000, data);
		checkWord("pipelined unmapped 0x5000", 16'h0000, data);
		busRead(16'hBFFF, data);
		checkWord("pipelined RAM last word", 16'h5AA5, data);
		busRead(16'h8000, data);
		checkWord("pipelined RAM first word", 16'hC0DE, data);
		busRead(16'h001F, data);
		checkWord("pipelined ROM word 31", 16'h1F1F ^ 16'hA5A5, data);

		// same cycle read sees old data and the next read the new data
		busWrite(16'h8123, 16'h1111);
		ADDRESS = 16'h8123;
		DATA_IN = 16'h2222;
		memWR = 1'b1;
		@(negedge CLK);
		memWR = 1'b0;
		checkWord("RAM read during write", 16'h1111, DATA_OUT);
		@(negedge CLK);
		checkWord("RAM read after write", 16'h2222, DATA_OUT);

		// 0x9000 shares its low address bits with 0x5000
		busWrite(16'h9000, 16'h3C3C);
		busWrite(16'h5000, 16'hFFFF); // dropped
		busRead(16'h5000, data);
		checkWord("unmapped 0x5000", 16'h0000, data);
		busRead(16'h9000, data);
		checkWord("RAM 0x9000 after unmapped write", 16'h3C3C, data);
		busRead(16'h4000, data);
		checkWord("unmapped 0x4000", 16'h0000, data);
		busRead(16'hC000, data);
		checkWord("unmapped 0xC000", 16'h0000, data);
		busRead(16'h1300, data);
		checkWord("unmapped 0x1300", 16'h0000, data);
	endtask

	task automatic gpioPins();
		wordT data;
		busWrite(GPIO_OUT_REG, 16'h000A);
		checkWord("gpioOut", 16'h000A, wordT'(gpioOut));
		busRead(GPIO_OUT_REG, data);
		checkWord("gpio output register", 16'h000A, data);
		gpioIn = 6'h2D;
		busRead(GPIO_IN_REG, data);
		checkWord("gpio input after one clock", 16'h0000, data);
		busRead(GPIO_IN_REG, data);
		checkWord("gpio input after two clocks", 16'h0000, data);
		busRead(GPIO_IN_REG, data);
		checkWord("gpio input after three clocks", 16'h002D, data);
	endtask

	task automatic pwmDuties();
		dutyT duties [PWM_CHANNELS];
		int highCount [PWM_CHANNELS];
		wordT data;
		duties[0] = 8'h11;
		duties[1] = 8'h80;
		duties[2] = 8'hFF;
		for (int ch = 0; ch < PWM_CHANNELS; ch++) begin
			busWrite(PWM_BASE + addrT'(ch), wordT'(duties[ch]));
		end
		for (int ch = 0; ch < PWM_CHANNELS; ch++) begin
			busRead(PWM_BASE + addrT'(ch), data);
			checkWord($sformatf("pwm duty %0d", ch), wordT'(duties[ch]), data);
			highCount[ch] = 0;
		end
		busRead(PWM_BASE + 16'h0003, data);
		checkWord("pwm offset 3", 16'h0000, data);
		repeat (256) begin
			@(negedge CLK);
			for (int ch = 0; ch < PWM_CHANNELS; ch++) begin
				if (ledPins[ch] === 1'b1) begin
					highCount[ch]++;
				end
			end
		end
		for (int ch = 0; ch < PWM_CHANNELS; ch++) begin
			checkWord($sformatf("ledPins[%0d] high cycles", ch), wordT'(duties[ch]),
				wordT'(highCount[ch]));
		end
	endtask

	task automatic uartFrame();
		logic [7:0] txByte;
		wordT status;
		int polls;
		logic idleOk;
		txByte = 8'($urandom & 32'hFF);
		busWrite(UART_DATA, {8'h00, txByte}); // half a cycle into the start bit
		busRead(UART_STATUS, status);
		checkWord("uart status after write", 16'h0001, status);
		busWrite(UART_DATA, 16'h00FF); // dropped while busy
		repeat (BAUD_DIV / 2 - 2) @(negedge CLK);
		checkPin("txPin start bit", 1'b0, txPin);
		for (int i = 0; i < 8; i++) begin
			repeat (BAUD_DIV) @(negedge CLK);
			checkPin($sformatf("txPin data bit %0d", i), txByte[i], txPin);
		end
		repeat (BAUD_DIV) @(negedge CLK);
		checkPin("txPin stop bit", 1'b1, txPin);
		busRead(UART_STATUS, status);
		checkWord("uart status in stop bit", 16'h0001, status);
		polls = 0;
		do begin
			busRead(UART_STATUS, status);
			polls++;
		end while (status !== 16'h0000 && polls < 2 * BAUD_DIV);
		if (status !== 16'h0000) begin
			errorCount++;
			$display("uart busy flag did not clear after the stop bit");
		end
		idleOk = 1'b1;
		repeat (2 * BAUD_DIV) begin
			@(negedge CLK);
			if (txPin !== 1'b1) begin
				idleOk = 1'b0;
			end
		end
		checkPin("txPin held idle after frame", 1'b1, idleOk);
		busRead(UART_STATUS, status);
		checkWord("uart status after frame", 16'h0000, status);
	endtask

	initial begin
		seedValue = $urandom(SEED);
		RSTb = 1'b0;
		ADDRESS = '0;
		DATA_IN = '0;
		memWR = 1'b0;
		gpioIn = '0;
		repeat (4) @(negedge CLK);
		RSTb = 1'b1;

		resetState();
		romReadback();
		ramReadback();
		gpioPins();
		pwmDuties();
		uartFrame();

		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
